//--- mini6502.f
+incdir+design
design/mini6502_pkg.sv
design/mini6502_alu.sv
design/mini6502_decode.sv
design/mini6502_sequencer.sv
design/mini6502_datapath.sv
design/mini6502.sv
dv/mini6502_assertions.sv
dv/mini6502_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the mini6502 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mini6502.f \
    --top-module mini6502_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Compile step failed"
    exit 1
fi

./obj_dir/Vmini6502_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

//--- dv/mini6502_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "mini6502_settings.svh"

module mini6502_tb import mini6502_pkg::*;;

    localparam int NUM_RUNS       = 32;     // Programs run over all tests
    localparam int RUN_CYCLES     = 240;    // Longest program with room for stalls
    localparam int TIMEOUT_CYCLES = NUM_RUNS * RUN_CYCLES;

    logic        clock;
    logic        reset;
    logic        enable;
    logic [7:0]  data_in;
    logic [15:0] address;
    logic [7:0]  data_out;
    logic        write_enable;
    logic        sync;
    logic [7:0]  debug_opcode;
    logic [15:0] debug_pc;
    logic [7:0]  debug_a;
    logic [7:0]  debug_x;
    logic [7:0]  debug_y;
    logic [3:0]  debug_flags;

    logic [7:0]  mem [0:65535];
    logic [7:0]  read_byte;
    logic [15:0] asm_pc;                    // Next free program byte
    logic [15:0] end_addr;                  // Address of the closing JMP to itself
    logic [31:0] lfsr_state;
    logic [7:0]  ls_data [0:8];             // Load/store bytes kept for the stalled rerun
    logic        gaps_on;
    int          errors;
    int          checks;
    int          cycle_count;
    int          since_sync;
    int          gaps[$];                   // Enabled cycles per instruction

    mini6502 i_dut (
        .clock        (clock),
        .reset        (reset),
        .enable       (enable),
        .data_in      (data_in),
        .address      (address),
        .data_out     (data_out),
        .write_enable (write_enable),
        .sync         (sync),
        .debug_opcode (debug_opcode),
        .debug_pc     (debug_pc),
        .debug_a      (debug_a),
        .debug_x      (debug_x),
        .debug_y      (debug_y),
        .debug_flags  (debug_flags)
    );

    initial
    begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Memory latches the bus on an enabled edge and read data follows shortly after
    always @(posedge clock)
    begin
        if (enable)
        begin
            if (write_enable)
                mem[address] = data_out;
            read_byte = mem[address];
        end
        #2;
        data_in = read_byte;
    end

    always @(posedge clock)
    begin
        #2;
        if (gaps_on)
            enable = random_bit();          // Roughly half the cycles stall
        else
            enable = 1'b1;
    end

    // Instruction length counted from one fetch to the next
    always @(negedge clock)
    begin
        if (reset)
            since_sync = 0;
        else if (enable)
        begin
            if (sync)
            begin
                if (since_sync != 0)
                    gaps.push_back(since_sync);
                since_sync = 1;
            end
            else
                since_sync++;
        end
    end

    always @(posedge clock)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: no result after %0d cycles, %0d errors so far",
                     cycle_count, errors);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic logic random_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};  // Taps 32, 22, 2, 1
        return fb;
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        for (int i = 0; i < 8; i++)
            b[i] = random_bit();
        return b;
    endfunction

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    task automatic fill_memory();
        for (int i = 0; i < 65536; i++)
            mem[i[15:0]] = i[15:8] ^ i[7:0] ^ 8'h5a;
        asm_pc = `RESET_PC;
    endtask

    task automatic emit(input logic [7:0] b);
        mem[asm_pc] = b;
        asm_pc = asm_pc + 16'd1;
    endtask

    task automatic emit_op_byte(input logic [7:0] op, input logic [7:0] operand);
        emit(op);
        emit(operand);
    endtask

    // Address operand goes low byte first
    task automatic emit_op_word(input logic [7:0] op, input logic [15:0] target);
        emit(op);
        emit(target[7:0]);
        emit(target[15:8]);
    endtask

    task automatic emit_halt();
        end_addr = asm_pc;
        emit_op_word(8'h4C, end_addr);
    endtask

    task automatic reset_dut();
        @(posedge clock);
        #2;
        reset = 1'b1;
        repeat (5) @(posedge clock);
        #2;
        reset = 1'b0;
    endtask

    // The last instruction commits on the edge that fetches the closing JMP
    task automatic run_program();
        reset_dut();
        forever
        begin
            @(negedge clock);
            if (sync && enable && address == end_addr)
                break;
        end
        @(posedge clock);
        #3;
    endtask

    task automatic reset_test();
        fill_memory();
        emit_halt();
        reset_dut();
        #1;
        check_value("sync", 16'(sync), 16'h1);
        check_value("address", address, `RESET_PC);
        check_value("write_enable", 16'(write_enable), 16'h0);
        check_value("debug_pc", debug_pc, `RESET_PC);
        check_value("debug_a", 16'(debug_a), 16'h0);
        check_value("debug_x", 16'(debug_x), 16'h0);
        check_value("debug_y", 16'(debug_y), 16'h0);
        check_value("debug_flags", 16'(debug_flags), 16'h0);
    endtask

    task automatic load_store_test(input logic new_data);
        if (new_data)
            for (int i = 0; i < 9; i++)
                ls_data[i] = random_byte();
        fill_memory();
        mem[16'h0010] = ls_data[3];
        mem[16'h0011] = ls_data[4];
        mem[16'h0012] = ls_data[5];
        mem[16'h3000] = ls_data[6];
        mem[16'h3001] = ls_data[7];
        mem[16'h3002] = ls_data[8];
        emit_op_byte(8'hA9, ls_data[0]);    // Immediate
        emit_op_byte(8'h85, 8'h40);
        emit_op_byte(8'hA2, ls_data[1]);
        emit_op_byte(8'h86, 8'h41);
        emit_op_byte(8'hA0, ls_data[2]);
        emit_op_byte(8'h84, 8'h42);
        emit_op_byte(8'hA5, 8'h10);         // Zero page
        emit_op_word(8'h8D, 16'h0300);
        emit_op_byte(8'hA6, 8'h11);
        emit_op_word(8'h8E, 16'h0301);
        emit_op_byte(8'hA4, 8'h12);
        emit_op_byte(8'h84, 8'h43);
        emit_op_word(8'hAD, 16'h3000);      // Absolute
        emit_op_byte(8'h85, 8'h44);
        emit_op_word(8'hAE, 16'h3001);
        emit_op_word(8'h8E, 16'h0302);
        emit_op_word(8'hAC, 16'h3002);
        emit_op_word(8'h8C, 16'h0303);
        emit_halt();
        run_program();
        check_value("mem[0040]", 16'(mem[16'h0040]), 16'(ls_data[0]));
        check_value("mem[0041]", 16'(mem[16'h0041]), 16'(ls_data[1]));
        check_value("mem[0042]", 16'(mem[16'h0042]), 16'(ls_data[2]));
        check_value("mem[0300]", 16'(mem[16'h0300]), 16'(ls_data[3]));
        check_value("mem[0301]", 16'(mem[16'h0301]), 16'(ls_data[4]));
        check_value("mem[0043]", 16'(mem[16'h0043]), 16'(ls_data[5]));
        check_value("mem[0044]", 16'(mem[16'h0044]), 16'(ls_data[6]));
        check_value("mem[0302]", 16'(mem[16'h0302]), 16'(ls_data[7]));
        check_value("mem[0303]", 16'(mem[16'h0303]), 16'(ls_data[8]));
        check_value("debug_a", 16'(debug_a), 16'(ls_data[6]));
        check_value("debug_x", 16'(debug_x), 16'(ls_data[7]));
        check_value("debug_y", 16'(debug_y), 16'(ls_data[8]));
        // Flags come from the last load by LDY
        check_value("debug_flags", 16'(debug_flags),
                    16'({ls_data[8][7], 1'b0, ls_data[8] == 8'h00, 1'b0}));
    endtask

    task automatic alu_case(input alu_op_t op, input int col, input logic [7:0] a,
                            input logic [7:0] b, input logic c);
        logic [8:0] s;
        logic [7:0] exp_a;
        logic       exp_c;
        logic       exp_v;
        fill_memory();
        emit_op_byte(8'hA9, a);
        emit(c ? 8'h38 : 8'h18);            // SEC or CLC
        if (col == 0)
            emit_op_byte({op, 3'b010, 2'b01}, b);
        else if (col == 1)
        begin
            mem[16'h0020] = b;
            emit_op_byte({op, 3'b001, 2'b01}, 8'h20);
        end
        else
        begin
            mem[16'h3100] = b;
            emit_op_word({op, 3'b011, 2'b01}, 16'h3100);
        end
        emit_halt();
        run_program();
        exp_a = a;
        exp_c = c;
        exp_v = 1'b0;
        case (op)
            alu_ora: exp_a = a | b;
            alu_and: exp_a = a & b;
            alu_eor: exp_a = a ^ b;
            alu_adc:
            begin
                s = {1'b0, a} + {1'b0, b} + {8'h00, c};
                exp_a = s[7:0];
                exp_c = s[8];
                exp_v = (a[7] == b[7]) && (s[7] != a[7]);
            end
            alu_sbc:
            begin
                s = {1'b0, a} + {1'b0, ~b} + {8'h00, c};  // Borrow is the inverted carry
                exp_a = s[7:0];
                exp_c = s[8];
                exp_v = (a[7] != b[7]) && (s[7] != a[7]);
            end
            alu_cmp: exp_c = (a >= b);      // N and Z follow A
            default: exp_a = a;
        endcase
        check_value("debug_a", 16'(debug_a), 16'(exp_a));
        check_value("debug_flags", 16'(debug_flags),
                    16'({exp_a[7], exp_v, exp_a == 8'h00, exp_c}));
    endtask

    task automatic alu_test();
        alu_op_t ops [0:5];
        ops = '{alu_ora, alu_and, alu_eor, alu_adc, alu_cmp, alu_sbc};
        for (int i = 0; i < 6; i++)
            for (int col = 0; col < 3; col++)
                alu_case(ops[i], col, random_byte(), random_byte(), random_bit());
    endtask

    // One load into a register followed by one implied transfer or count
    task automatic count_case(input logic [7:0] load_op, input logic [7:0] value,
                              input logic [7:0] op);
        logic [7:0] a;
        logic [7:0] x;
        logic [7:0] y;
        logic [7:0] r;
        fill_memory();
        emit_op_byte(load_op, value);
        emit(op);
        emit_halt();
        run_program();
        a = (load_op == 8'hA9) ? value : 8'h00;
        x = (load_op == 8'hA2) ? value : 8'h00;
        y = (load_op == 8'hA0) ? value : 8'h00;
        case (op)
            8'hE8:   x = x + 8'd1;          // INX
            8'hC8:   y = y + 8'd1;          // INY
            8'hCA:   x = x - 8'd1;          // DEX
            8'h88:   y = y - 8'd1;          // DEY
            8'hAA:   x = a;                 // TAX
            8'hA8:   y = a;                 // TAY
            8'h8A:   a = x;                 // TXA
            default: a = y;                 // TYA
        endcase
        // Flags follow the register that was written
        case (op)
            8'hE8, 8'hCA, 8'hAA: r = x;
            8'hC8, 8'h88, 8'hA8: r = y;
            default:             r = a;
        endcase
        check_value("debug_a", 16'(debug_a), 16'(a));
        check_value("debug_x", 16'(debug_x), 16'(x));
        check_value("debug_y", 16'(debug_y), 16'(y));
        check_value("debug_flags", 16'(debug_flags), 16'({r[7], 1'b0, r == 8'h00, 1'b0}));
    endtask

    task automatic count_test();
        count_case(8'hA2, 8'hFF, 8'hE8);    // Wrap to zero
        count_case(8'hA2, 8'h7F, 8'hE8);
        count_case(8'hA0, 8'hFF, 8'hC8);
        count_case(8'hA2, 8'h00, 8'hCA);    // Wrap to FF
        count_case(8'hA0, 8'h00, 8'h88);
        count_case(8'hA0, 8'h80, 8'h88);
        count_case(8'hA9, random_byte(), 8'hAA);
        count_case(8'hA9, 8'h80, 8'hA8);
        count_case(8'hA2, random_byte(), 8'h8A);
        count_case(8'hA0, random_byte(), 8'h98);
    endtask

    task automatic timing_test();
        int expected [0:6];
        expected = '{2, 2, 3, 4, 3, 4, 3};  // NOP, imm, zp, abs, STA zp, STA abs, JMP
        fill_memory();
        emit(8'hEA);
        emit_op_byte(8'hA9, 8'h01);
        emit_op_byte(8'hA5, 8'h10);
        emit_op_word(8'hAD, 16'h3000);
        emit_op_byte(8'h85, 8'h50);
        emit_op_word(8'h8D, 16'h3200);
        emit_op_word(8'h4C, 16'h0280);
        asm_pc = 16'h0280;                  // Only reached through the JMP
        emit_halt();
        gaps.delete();
        run_program();
        // PC sits one past the opcode fetched at the JMP target
        check_value("debug_pc", debug_pc, end_addr + 16'd1);
        check_value("debug_opcode", 16'(debug_opcode), 16'h004C);
        check_value("mem[3200]", 16'(mem[16'h3200]), 16'(mem[16'h3000]));
        if (gaps.size() < 7)
        begin
            errors++;
            $display("Fewer instruction fetches were seen than the timing program holds");
        end
        else
            for (int i = 0; i < 7; i++)
                check_value($sformatf("cycles of instruction %0d", i),
                            16'(gaps[i]), 16'(expected[i]));
    endtask

    initial
    begin
        reset       = 1'b1;
        enable      = 1'b1;
        data_in     = 8'h00;
        read_byte   = 8'h00;
        gaps_on     = 1'b0;
        lfsr_state  = 32'h2c18_14cc;
        errors      = 0;
        checks      = 0;
        cycle_count = 0;
        since_sync  = 0;
        reset_test();
        load_store_test(1'b1);
        alu_test();
        count_test();
        timing_test();
        gaps_on = 1'b1;                     // Same load/store program under stalls
        load_store_test(1'b0);
        gaps_on = 1'b0;
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/mini6502_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module mini6502_assertions (
    input wire logic        clock,
    input wire logic        reset,
    input wire logic        enable,
    input wire logic [15:0] address,
    input wire logic [7:0]  data_out,
    input wire logic        write_enable,
    input wire logic        sync,
    input wire logic [15:0] debug_pc,
    input wire logic [7:0]  debug_a
);

    // A stalled cycle leaves every output where it was
    hold_while_stalled: assert property (@(posedge clock) disable iff (reset)
        !enable |=> $stable(address) && $stable(data_out) && $stable(write_enable)
                    && $stable(sync) && $stable(debug_pc) && $stable(debug_a))
        else $error("outputs moved during a stalled cycle");

    no_write_on_fetch: assert property (@(posedge clock) disable iff (reset)
        !(write_enable && sync))
        else $error("write during an opcode fetch");

    fetch_after_reset: assert property (@(posedge clock) $fell(reset) |-> sync)
        else $error("first cycle after reset is not a fetch");

endmodule

bind mini6502 mini6502_assertions i_assertions (
    .clock        (clock),
    .reset        (reset),
    .enable       (enable),
    .address      (address),
    .data_out     (data_out),
    .write_enable (write_enable),
    .sync         (sync),
    .debug_pc     (debug_pc),
    .debug_a      (debug_a)
);

`default_nettype wire

//--- design/mini6502.sv
`timescale 1ns/10ps
`default_nettype none
`include "mini6502_settings.svh"

module mini6502 import mini6502_pkg::*; (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   enable,
    input  logic [`DATA_WIDTH-1:0] data_in,
    output logic [`ADDR_WIDTH-1:0] address,
    output logic [`DATA_WIDTH-1:0] data_out,
    output logic                   write_enable,
    output logic                   sync,
    output logic [`DATA_WIDTH-1:0] debug_opcode,
    output logic [`ADDR_WIDTH-1:0] debug_pc,
    output logic [`DATA_WIDTH-1:0] debug_a,
    output logic [`DATA_WIDTH-1:0] debug_x,
    output logic [`DATA_WIDTH-1:0] debug_y,
    output logic [3:0]             debug_flags     // N, V, Z, C
);

    logic [`DATA_WIDTH-1:0] opcode;
    addr_mode_t             mode;
    addr_sel_t              addr_sel;
    alu_op_t                alu_op;
    db_src_t                db_src;
    store_src_t             store_src;
    logic                   is_store;
    logic                   pc_inc;
    logic                   pc_load;
    logic                   commit;
    logic                   load_a;
    logic                   load_x;
    logic                   load_y;
    logic                   update_nz;
    logic                   update_cv;
    logic                   carry_op;
    logic                   count_down;

    mini6502_sequencer i_sequencer (
        .clock        (clock),
        .reset        (reset),
        .enable       (enable),
        .data_in      (data_in),
        .mode         (mode),
        .is_store     (is_store),
        .opcode       (opcode),
        .addr_sel     (addr_sel),
        .pc_inc       (pc_inc),
        .pc_load      (pc_load),
        .write_enable (write_enable),
        .commit       (commit),
        .sync         (sync)
    );

    mini6502_decode i_decode (
        .opcode     (opcode),
        .mode       (mode),
        .is_store   (is_store),
        .alu_op     (alu_op),
        .db_src     (db_src),
        .store_src  (store_src),
        .load_a     (load_a),
        .load_x     (load_x),
        .load_y     (load_y),
        .update_nz  (update_nz),
        .update_cv  (update_cv),
        .carry_op   (carry_op),
        .count_down (count_down)
    );

    mini6502_datapath i_datapath (
        .clock      (clock),
        .reset      (reset),
        .enable     (enable),
        .data_in    (data_in),
        .opcode     (opcode),
        .addr_sel   (addr_sel),
        .pc_inc     (pc_inc),
        .pc_load    (pc_load),
        .commit     (commit),
        .alu_op     (alu_op),
        .db_src     (db_src),
        .store_src  (store_src),
        .load_a     (load_a),
        .load_x     (load_x),
        .load_y     (load_y),
        .update_nz  (update_nz),
        .update_cv  (update_cv),
        .carry_op   (carry_op),
        .count_down (count_down),
        .address    (address),
        .data_out   (data_out),
        .pc         (debug_pc),
        .reg_a      (debug_a),
        .reg_x      (debug_x),
        .reg_y      (debug_y),
        .flags      (debug_flags)
    );

    assign debug_opcode = opcode;

endmodule

`default_nettype wire

//--- design/mini6502_datapath.sv
`timescale 1ns/10ps
`default_nettype none
`include "mini6502_settings.svh"

module mini6502_datapath import mini6502_pkg::*; (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   enable,
    input  logic [`DATA_WIDTH-1:0] data_in,
    input  logic [`DATA_WIDTH-1:0] opcode,
    input  addr_sel_t              addr_sel,
    input  logic                   pc_inc,
    input  logic                   pc_load,
    input  logic                   commit,
    input  alu_op_t                alu_op,
    input  db_src_t                db_src,
    input  store_src_t             store_src,
    input  logic                   load_a,
    input  logic                   load_x,
    input  logic                   load_y,
    input  logic                   update_nz,
    input  logic                   update_cv,
    input  logic                   carry_op,
    input  logic                   count_down,
    output logic [`ADDR_WIDTH-1:0] address,
    output logic [`DATA_WIDTH-1:0] data_out,
    output logic [`ADDR_WIDTH-1:0] pc,
    output logic [`DATA_WIDTH-1:0] reg_a,
    output logic [`DATA_WIDTH-1:0] reg_x,
    output logic [`DATA_WIDTH-1:0] reg_y,
    output logic [3:0]             flags
);

    logic                   flag_n;
    logic                   flag_v;
    logic                   flag_z;
    logic                   flag_c;
    logic [`DATA_WIDTH-1:0] operand_lo;     // Last byte read, low half of an address
    logic [`ADDR_WIDTH-1:0] abs_address;
    logic [`DATA_WIDTH-1:0] alu_result;
    logic                   alu_c;
    logic                   alu_v;
    logic [`DATA_WIDTH-1:0] x_count;
    logic [`DATA_WIDTH-1:0] y_count;
    logic [`DATA_WIDTH-1:0] data_bus;

    mini6502_alu i_alu (
        .a_in   (reg_a),
        .b_in   (data_in),
        .c_in   (flag_c),
        .op     (alu_op),
        .result (alu_result),
        .c_out  (alu_c),
        .v_out  (alu_v)
    );

    assign abs_address = {data_in, operand_lo};

    always_comb
    begin
        case (addr_sel)
            addr_zp:  address = {`ZERO_PAGE, data_in};
            addr_abs: address = abs_address;
            default:  address = pc;
        endcase
        case (store_src)
            store_x: data_out = reg_x;
            store_y: data_out = reg_y;
            default: data_out = reg_a;
        endcase
    end

    // Step is +1 only when the counted register is written, so TXA/TYA pass unchanged
    assign x_count = reg_x + (count_down ? {`DATA_WIDTH{1'b1}}
                                         : {{(`DATA_WIDTH-1){1'b0}}, load_x});
    assign y_count = reg_y + (count_down ? {`DATA_WIDTH{1'b1}}
                                         : {{(`DATA_WIDTH-1){1'b0}}, load_y});

    always_comb
    begin
        case (db_src)
            db_mem:     data_bus = data_in;     // Byte read in the last cycle
            db_alu:     data_bus = alu_result;
            db_a:       data_bus = reg_a;
            db_x_count: data_bus = x_count;
            db_y_count: data_bus = y_count;
            default:    data_bus = '0;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (reset)
            pc <= `RESET_PC;
        else if (enable)
            pc <= (pc_load ? abs_address : pc) + {{(`ADDR_WIDTH-1){1'b0}}, pc_inc};
        if (enable)
            operand_lo <= data_in;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            reg_a  <= '0;
            reg_x  <= '0;
            reg_y  <= '0;
            flag_n <= 1'b0;
            flag_v <= 1'b0;
            flag_z <= 1'b0;
            flag_c <= 1'b0;
        end
        else if (commit)
        begin
            if (load_a) reg_a <= data_bus;
            if (load_x) reg_x <= data_bus;
            if (load_y) reg_y <= data_bus;
            if (update_nz)
            begin
                flag_n <= data_bus[`DATA_WIDTH-1];
                flag_z <= (data_bus == '0);
            end
            if (update_cv)
            begin
                flag_c <= alu_c;
                if (alu_op != alu_cmp)  // Compare keeps V
                    flag_v <= alu_v;
            end
            if (carry_op)
                flag_c <= opcode[5];    // CLC/SEC
        end
    end

    assign flags = {flag_n, flag_v, flag_z, flag_c};

endmodule

`default_nettype wire

//--- design/mini6502_sequencer.sv
`timescale 1ns/10ps
`default_nettype none
`include "mini6502_settings.svh"

module mini6502_sequencer import mini6502_pkg::*; (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   enable,
    input  logic [`DATA_WIDTH-1:0] data_in,
    input  addr_mode_t             mode,
    input  logic                   is_store,
    output logic [`DATA_WIDTH-1:0] opcode,
    output addr_sel_t              addr_sel,
    output logic                   pc_inc,
    output logic                   pc_load,
    output logic                   write_enable,
    output logic                   commit,
    output logic                   sync
);

    localparam logic [`DATA_WIDTH-1:0] RESET_OPCODE = 8'hEA;  // NOP, nothing to commit

    cpu_state_t             state;
    cpu_state_t             state_next;
    logic [`DATA_WIDTH-1:0] opcode_reg;

    // New opcode sits on data_in during st_byte2, the register keeps it until the next one
    assign opcode = (state == st_byte2) ? data_in : opcode_reg;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state      <= st_opcode;
            opcode_reg <= RESET_OPCODE;
        end
        else if (enable)
        begin
            state <= state_next;
            if (state == st_byte2)
                opcode_reg <= data_in;
        end
    end

    always_comb
    begin
        state_next   = st_opcode;
        addr_sel     = addr_pc;
        pc_inc       = 1'b0;
        pc_load      = 1'b0;
        write_enable = 1'b0;
        case (state)
            st_opcode:
            begin
                state_next = st_byte2;
                pc_inc     = 1'b1;
                // High byte of a jump target arrives now, fetch from the target directly
                if (mode == mode_jump)
                begin
                    addr_sel = addr_abs;
                    pc_load  = 1'b1;
                end
            end
            st_byte2:
            begin
                pc_inc = (mode != mode_implied);  // Implied re-reads the next opcode
                case (mode)
                    mode_zeropage: state_next = st_data;
                    mode_absolute: state_next = st_byte3;
                    mode_jump:     state_next = st_byte3;
                    default:       state_next = st_opcode;
                endcase
            end
            st_byte3:
            begin
                pc_inc     = 1'b1;              // Read high address byte
                state_next = (mode == mode_jump) ? st_opcode : st_data;
            end
            default:
            begin
                addr_sel     = (mode == mode_zeropage) ? addr_zp : addr_abs;
                write_enable = is_store;        // Store writes in its last cycle
            end
        endcase
    end

    assign sync   = (state == st_opcode);
    assign commit = sync & enable;          // Results of the previous instruction

endmodule

`default_nettype wire

//--- design/mini6502_decode.sv
`timescale 1ns/10ps
`default_nettype none
`include "mini6502_settings.svh"

module mini6502_decode import mini6502_pkg::*; (
    input  logic [`DATA_WIDTH-1:0] opcode,
    output addr_mode_t             mode,
    output logic                   is_store,
    output alu_op_t                alu_op,
    output db_src_t                db_src,
    output store_src_t             store_src,
    output logic                   load_a,
    output logic                   load_x,
    output logic                   load_y,
    output logic                   update_nz,
    output logic                   update_cv,
    output logic                   carry_op,
    output logic                   count_down
);

    // Address columns, opcode bits 4:2
    wire logic col_zp  = opcode ==? 8'b???_001_??;  // $00
    wire logic col_abs = opcode ==? 8'b???_011_??;  // $0000
    wire logic imm_a   = opcode ==? 8'b???_010_01;  // ALU #$00
    wire logic imm_xy  = opcode ==? 8'b101_000_?0;  // LDX/LDY #$00
    wire logic col_mem = col_zp | col_abs;

    // Groups
    wire logic lda   = (opcode ==? 8'b101_???_01) & (col_mem | imm_a);
    wire logic ldx   = (opcode ==? 8'b101_???_10) & (col_mem | imm_xy);
    wire logic ldy   = (opcode ==? 8'b101_???_00) & (col_mem | imm_xy);
    wire logic arith = (opcode ==? 8'b???_???_01) & ~(opcode ==? 8'b10?_???_??)
                       & (col_mem | imm_a);     // ORA/AND/EOR/ADC/CMP/SBC
    wire logic store = (opcode ==? 8'b100_???_??) & ~(opcode ==? 8'b???_???_11) & col_mem;
    wire logic cmp   = arith & (opcode[7:5] == 3'b110);
    wire logic adc_sbc = arith & (opcode[6:5] == 2'b11);

    // Single opcodes
    wire logic jmp = opcode == 8'h4C;
    wire logic inx = opcode == 8'hE8;
    wire logic iny = opcode == 8'hC8;
    wire logic dex = opcode == 8'hCA;
    wire logic dey = opcode == 8'h88;
    wire logic tax = opcode == 8'hAA;
    wire logic tay = opcode == 8'hA8;
    wire logic txa = opcode == 8'h8A;
    wire logic tya = opcode == 8'h98;
    wire logic clc_sec = opcode ==? 8'b00?_110_00;  // Bit 5 gives the new carry

    wire logic mem_op = lda | ldx | ldy | arith | store;

    always_comb
    begin
        mode = mode_implied;                    // Anything unlisted runs as a NOP
        if (jmp)
            mode = mode_jump;
        else if (mem_op)
            mode = col_zp ? mode_zeropage : (col_abs ? mode_absolute : mode_immediate);

        db_src = db_none;
        if (lda | ldx | ldy)
            db_src = db_mem;
        else if (arith)
            db_src = db_alu;
        else if (tax | tay)
            db_src = db_a;
        else if (txa | inx | dex)
            db_src = db_x_count;
        else if (tya | iny | dey)
            db_src = db_y_count;
    end

    assign is_store   = store;
    assign store_src  = (opcode[1:0] == 2'b01) ? store_a : (opcode[1] ? store_x : store_y);
    assign alu_op     = arith ? alu_op_t'(opcode[7:5]) : alu_pass;
    assign load_a     = lda | (arith & ~cmp) | txa | tya;  // CMP leaves A alone
    assign load_x     = ldx | tax | inx | dex;
    assign load_y     = ldy | tay | iny | dey;
    assign update_nz  = load_a | load_x | load_y | cmp;
    assign update_cv  = adc_sbc | cmp;
    assign carry_op   = clc_sec;
    assign count_down = dex | dey;

endmodule

`default_nettype wire

//--- design/mini6502_alu.sv
`timescale 1ns/10ps
`default_nettype none
`include "mini6502_settings.svh"

module mini6502_alu import mini6502_pkg::*; (
    input  logic [`DATA_WIDTH-1:0] a_in,
    input  logic [`DATA_WIDTH-1:0] b_in,
    input  logic                   c_in,
    input  alu_op_t                op,
    output logic [`DATA_WIDTH-1:0] result,
    output logic                   c_out,
    output logic                   v_out
);

    logic                   subtract;
    logic                   carry_in;
    logic [`DATA_WIDTH-1:0] addend;
    logic [`DATA_WIDTH:0]   sum;

    assign subtract = op[2];                            // CMP and SBC
    assign addend   = subtract ? ~b_in : b_in;          // Ones complement for subtraction
    assign carry_in = (op == alu_cmp) ? 1'b1 : c_in;    // Compare ignores the carry flag
    assign sum      = {1'b0, a_in} + {1'b0, addend} + {{`DATA_WIDTH{1'b0}}, carry_in};

    always_comb
    begin
        case (op)
            alu_ora: result = a_in | b_in;
            alu_and: result = a_in & b_in;
            alu_eor: result = a_in ^ b_in;
            alu_adc: result = sum[`DATA_WIDTH-1:0];
            alu_cmp: result = a_in;             // A passes to the flags path
            alu_sbc: result = sum[`DATA_WIDTH-1:0];
            default: result = b_in;             // Load
        endcase
    end

    assign c_out = sum[`DATA_WIDTH];
    // Both inputs agree in sign and the sum disagrees
    assign v_out = (a_in[`DATA_WIDTH-1] ^ sum[`DATA_WIDTH-1])
                 & (addend[`DATA_WIDTH-1] ^ sum[`DATA_WIDTH-1]);

endmodule

`default_nettype wire

//--- design/mini6502_pkg.sv
`default_nettype none

package mini6502_pkg;

    // Cycle within an instruction
    typedef enum logic [1:0] {
        st_opcode,      // Opcode fetch, previous result committed
        st_byte2,       // Second instruction byte
        st_byte3,       // Third instruction byte, high address
        st_data         // Memory data read or write
    } cpu_state_t;

    typedef enum logic [2:0] {
        mode_implied,
        mode_immediate,
        mode_zeropage,
        mode_absolute,
        mode_jump
    } addr_mode_t;

    // Bus address source
    typedef enum logic [1:0] {
        addr_pc,        // Program counter
        addr_zp,        // Zero page plus data_in
        addr_abs        // data_in high, latched low byte
    } addr_sel_t;

    // Encoded as opcode bits 7:5 of the ALU column
    typedef enum logic [2:0] {
        alu_ora  = 3'd0,
        alu_and  = 3'd1,
        alu_eor  = 3'd2,
        alu_adc  = 3'd3,
        alu_pass = 3'd5,
        alu_cmp  = 3'd6,
        alu_sbc  = 3'd7
    } alu_op_t;

    typedef enum logic [2:0] {db_none, db_mem, db_alu, db_a, db_x_count, db_y_count} db_src_t;

    typedef enum logic [1:0] {store_a, store_x, store_y} store_src_t;

endpackage

`default_nettype wire

//--- design/mini6502_settings.svh
`ifndef MINI6502_SETTINGS_SVH
`define MINI6502_SETTINGS_SVH

// Byte width of registers and the data bus
`define DATA_WIDTH 8

// Bus address width
`define ADDR_WIDTH 16

// Address of the first opcode fetch after reset
`define RESET_PC 16'h0200

// High address byte of every zero-page access
`define ZERO_PAGE 8'h00

`endif
